// ==== list.f ====
+incdir+include
rtl/cu_pkg.sv
rtl/trap_sequencer.sv
rtl/frontend_ctrl.sv
rtl/backend_ctrl.sv
rtl/control_unit.sv
tb/tb_control_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build the control unit testbench with Verilator, run it, check the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f list.f \
    --top-module tb_control_unit -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
exit 1

// ==== tb/tb_control_unit.sv ====
/*
 * Control unit testbench
 * Directed tests of redirects, stalls, flushes, checkpoints and commit control
 */
`timescale 1ns/10ps
`default_nettype none

`include "cu_cfg.svh"

module tb_control_unit
    import cu_pkg::*;
();

    logic                     clk_i;
    logic                     rstn_i;
    id_rpt_t                  id_i;
    ir_rpt_t                  ir_i;
    rr_rpt_t                  rr_i;
    exe_rpt_t                 exe_i;
    wb_rpt_t                  wb_i;
    commit_rpt_t              commit_i;
    csr_rpt_t                 csr_i;
    logic                     miss_icache_i;
    logic                     ready_icache_i;
    stall_vec_t               stall_o;
    flush_vec_t               flush_o;
    next_pc_sel_e             next_pc_o;
    sel_addr_e                sel_addr_o;
    logic                     invalidate_icache_o;
    logic                     invalidate_buffer_o;
    chkp_ctrl_t               chkp_o;
    commit_ctrl_t             commit_ctrl_o;
    logic                     flush_gl_o;
    logic [`CU_GL_IDX_W-1:0]  flush_gl_index_o;

    integer seed;
    int     test_errs;
    int     total_errs;
    int     tests_run;
    int     tests_failed;

    control_unit u_dut (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .id_i                (id_i),
        .ir_i                (ir_i),
        .rr_i                (rr_i),
        .exe_i               (exe_i),
        .wb_i                (wb_i),
        .commit_i            (commit_i),
        .csr_i               (csr_i),
        .miss_icache_i       (miss_icache_i),
        .ready_icache_i      (ready_icache_i),
        .stall_o             (stall_o),
        .flush_o             (flush_o),
        .next_pc_o           (next_pc_o),
        .sel_addr_o          (sel_addr_o),
        .invalidate_icache_o (invalidate_icache_o),
        .invalidate_buffer_o (invalidate_buffer_o),
        .chkp_o              (chkp_o),
        .commit_ctrl_o       (commit_ctrl_o),
        .flush_gl_o          (flush_gl_o),
        .flush_gl_index_o    (flush_gl_index_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // reset held for 16 cycles, released on a falling edge
    initial begin
        rstn_i = 1'b0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
    end

    task automatic check_val(input string name, input logic [7:0] exp_v, input logic [7:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR t=%0t %s expected 'h%0h actual 'h%0h", $time, name, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (exp_v !== act_v) begin
            $display("ERR t=%0t %s expected %0b actual %0b", $time, name, exp_v, act_v);
            test_errs++;
        end
    endtask

    // stall order if1 if2 id iq ir rr exe commit, flush order if id ir rr exe kill
    task automatic check_pipe(input logic [7:0] stall_exp, input logic [7:0] flush_exp,
                              input next_pc_sel_e pc_exp, input sel_addr_e sel_exp);
        check_val("stall_o", stall_exp, 8'(stall_o));
        check_val("flush_o", flush_exp, 8'(flush_o));
        check_val("next_pc_o", 8'(pc_exp), 8'(next_pc_o));
        check_val("sel_addr_o", 8'(sel_exp), 8'(sel_addr_o));
    endtask

    // wait for the falling edge, then return every input to idle
    task automatic next_fall();
        @(negedge clk_i);
        id_i           = '0;
        ir_i           = '0;
        rr_i           = '0;
        exe_i          = '0;
        wb_i           = '0;
        commit_i       = '0;
        csr_i          = '0;
        miss_icache_i  = 1'b0;
        ready_icache_i = 1'b1;
    endtask

    task automatic finish_test(input string name);
        $display("%s done, %0d errors", name, test_errs);
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    task automatic idle_after_reset();
        next_fall();
        #1;
        check_pipe(8'h00, 8'h00, NEXT_PC_SEL_BP_OR_PC_4, SEL_JUMP_DECODE);
        check_bit("enable_commit", 1'b1, commit_ctrl_o.enable_commit);
        check_val("chkp_o", 8'h00, 8'(chkp_o));
        finish_test("idle_after_reset");
    endtask

    task automatic wb_mispredict();
        logic [31:0]             rnd;
        logic [`CU_GL_IDX_W-1:0] idx;
        logic [`CU_CHKP_W-1:0]   ck;
        rnd = $random(seed);
        idx = rnd[`CU_GL_IDX_W-1:0];
        ck  = rnd[`CU_CHKP_W+15:16];
        next_fall();
        wb_i.valid           = 1'b1;
        wb_i.checkpoint_done = 1'b1;
        wb_i.chkp            = ck;
        wb_i.gl_index        = idx;
        #1;
        check_pipe(8'h00, 8'h3d, NEXT_PC_SEL_JUMP, SEL_JUMP_EXECUTION);
        check_bit("flush_gl_o", 1'b1, flush_gl_o);
        check_val("flush_gl_index_o", 8'(idx), 8'(flush_gl_index_o));
        check_bit("do_recover", 1'b1, chkp_o.do_recover);
        check_bit("delete_checkpoint", 1'b0, chkp_o.delete_checkpoint);
        check_val("recover_checkpoint", 8'(ck), 8'(chkp_o.recover_checkpoint));
        // correct branch only frees its checkpoint
        next_fall();
        wb_i.valid           = 1'b1;
        wb_i.correct_pred    = 1'b1;
        wb_i.checkpoint_done = 1'b1;
        #1;
        check_pipe(8'h00, 8'h00, NEXT_PC_SEL_BP_OR_PC_4, SEL_JUMP_DECODE);
        check_bit("do_recover", 1'b0, chkp_o.do_recover);
        check_bit("delete_checkpoint", 1'b1, chkp_o.delete_checkpoint);
        check_bit("flush_gl_o", 1'b0, flush_gl_o);
        check_val("flush_gl_index_o", 8'h00, 8'(flush_gl_index_o));
        finish_test("wb_mispredict");
    endtask

    task automatic commit_exception();
        next_fall();
        commit_i.valid      = 1'b1;
        commit_i.xcpt       = 1'b1;
        commit_i.retire     = '1;
        commit_i.regfile_we = '1;
        #1;
        check_bit("enable_commit", 1'b0, commit_ctrl_o.enable_commit);
        check_val("enable_commit_update", 8'h00, 8'(commit_ctrl_o.enable_commit_update));
        // trap pulse cycle
        next_fall();
        commit_i.valid = 1'b1;
        #1;
        check_pipe(8'h00, 8'h3e, NEXT_PC_SEL_JUMP, SEL_JUMP_CSR);
        check_bit("recover_commit", 1'b1, chkp_o.recover_commit);
        check_bit("flush_gl_commit", 1'b1, commit_ctrl_o.flush_gl_commit);
        check_bit("invalidate_buffer_o", 1'b1, invalidate_buffer_o);
        next_fall();
        #1;
        check_pipe(8'h00, 8'h00, NEXT_PC_SEL_BP_OR_PC_4, SEL_JUMP_DECODE);
        check_bit("recover_commit", 1'b0, chkp_o.recover_commit);
        check_bit("flush_gl_commit", 1'b0, commit_ctrl_o.flush_gl_commit);
        check_bit("invalidate_buffer_o", 1'b0, invalidate_buffer_o);
        finish_test("commit_exception");
    endtask

    task automatic csr_fence();
        next_fall();
        id_i.valid           = 1'b1;
        id_i.stall_csr_fence = 1'b1;
        #1;
        check_pipe(8'h00, 8'h20, NEXT_PC_SEL_KEEP_PC, SEL_JUMP_DECODE);
        // fence now in flight
        next_fall();
        #1;
        check_val("next_pc_o", 8'(NEXT_PC_SEL_KEEP_PC), 8'(next_pc_o));
        next_fall();
        commit_i.valid           = 1'b1;
        commit_i.stall_csr_fence = 1'b1;
        #1;
        check_val("stall_o", 8'h80, 8'(stall_o));
        check_val("next_pc_o", 8'(NEXT_PC_SEL_KEEP_PC), 8'(next_pc_o));
        check_bit("invalidate_buffer_o", 1'b1, invalidate_buffer_o);
        next_fall();
        #1;
        check_pipe(8'h00, 8'h30, NEXT_PC_SEL_JUMP, SEL_JUMP_CSR_RW);
        next_fall();
        #1;
        check_pipe(8'h00, 8'h00, NEXT_PC_SEL_BP_OR_PC_4, SEL_JUMP_DECODE);
        finish_test("csr_fence");
    endtask

    // cause bits csr_stall exe gl_full empty_fl out_chkp full_iq miss not_ready
    task automatic stall_case(input logic [7:0] cause, input logic [7:0] stall_exp,
                              input logic [7:0] flush_exp);
        next_fall();
        csr_i.csr_stall         = cause[7];
        exe_i.stall             = cause[6];
        rr_i.gl_full            = cause[5];
        ir_i.empty_free_list    = cause[4];
        ir_i.out_of_checkpoints = cause[3];
        ir_i.full_iq            = cause[2];
        miss_icache_i           = cause[1];
        ready_icache_i          = ~cause[0];
        #1;
        check_val("stall_o", stall_exp, 8'(stall_o));
        check_val("flush_o", flush_exp, 8'(flush_o));
    endtask

    task automatic stall_priority();
        stall_case(8'h80, 8'hfe, 8'h00);
        stall_case(8'h40, 8'h1c, 8'h00);
        stall_case(8'h20, 8'h1c, 8'h04);
        stall_case(8'h10, 8'h10, 8'h00);
        stall_case(8'h08, 8'h10, 8'h00);
        stall_case(8'h04, 8'he0, 8'h00);
        stall_case(8'h02, 8'hc0, 8'h00);
        stall_case(8'h01, 8'h80, 8'h00);
        // pairs, higher rule wins
        stall_case(8'hc0, 8'hfe, 8'h00);
        stall_case(8'ha0, 8'hfe, 8'h04);
        stall_case(8'h60, 8'h1c, 8'h00);
        stall_case(8'h30, 8'h1c, 8'h04);
        stall_case(8'h06, 8'he0, 8'h00);
        stall_case(8'h03, 8'hc0, 8'h00);
        stall_case(8'h11, 8'h90, 8'h00);
        finish_test("stall_priority");
    endtask

    task automatic branch_rename(input logic out_chkp, input logic gl_full,
                                 input logic mispred, input logic exp_v);
        next_fall();
        ir_i.valid              = 1'b1;
        ir_i.is_branch          = 1'b1;
        ir_i.out_of_checkpoints = out_chkp;
        rr_i.gl_full            = gl_full;
        wb_i.valid              = mispred;
        wb_i.correct_pred       = ~mispred;
        #1;
        check_bit("do_checkpoint", exp_v, chkp_o.do_checkpoint);
    endtask

    task automatic checkpoint_take();
        branch_rename(1'b0, 1'b0, 1'b0, 1'b1);
        branch_rename(1'b1, 1'b0, 1'b0, 1'b0);
        branch_rename(1'b0, 1'b1, 1'b0, 1'b0);
        branch_rename(1'b0, 1'b0, 1'b1, 1'b0);
        next_fall();
        commit_i.valid   = 1'b1;
        commit_i.fence_i = 1'b1;
        #1;
        check_bit("invalidate_icache_o", 1'b1, invalidate_icache_o);
        check_bit("invalidate_buffer_o", 1'b1, invalidate_buffer_o);
        finish_test("checkpoint_take");
    endtask

    initial begin
        int wait_cnt;
        seed           = 32'ha45a6688;
        test_errs      = 0;
        total_errs     = 0;
        tests_run      = 0;
        tests_failed   = 0;
        id_i           = '0;
        ir_i           = '0;
        rr_i           = '0;
        exe_i          = '0;
        wb_i           = '0;
        commit_i       = '0;
        csr_i          = '0;
        miss_icache_i  = 1'b0;
        ready_icache_i = 1'b1;
        wait_cnt       = 0;
        while (rstn_i !== 1'b1 && wait_cnt < 40) begin
            @(posedge clk_i);
            wait_cnt++;
        end
        if (rstn_i !== 1'b1) begin
            $display("reset was not released within 40 cycles");
            $display("=== FAIL ===");
            $finish;
        end else begin
            idle_after_reset();
            wb_mispredict();
            commit_exception();
            csr_fence();
            stall_priority();
            checkpoint_take();
            $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
            if (total_errs == 0) begin
                $display("=== PASS ===");
            end else begin
                $display("=== FAIL ===");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/control_unit.sv ====
/*
 * Pipeline control unit
 * Joins the trap sequencer with the front-end and back-end control
 */
`timescale 1ns/10ps
`default_nettype none

`include "cu_cfg.svh"

module control_unit
    import cu_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire id_rpt_t               id_i,
    input  wire ir_rpt_t               ir_i,
    input  wire rr_rpt_t               rr_i,
    input  wire exe_rpt_t              exe_i,
    input  wire wb_rpt_t               wb_i,
    input  wire commit_rpt_t           commit_i,
    input  wire csr_rpt_t              csr_i,
    input  wire logic                  miss_icache_i,
    input  wire logic                  ready_icache_i,
    output stall_vec_t                 stall_o,
    output flush_vec_t                 flush_o,
    output next_pc_sel_e               next_pc_o,
    output sel_addr_e                  sel_addr_o,
    output logic                       invalidate_icache_o,
    output logic                       invalidate_buffer_o,
    output chkp_ctrl_t                 chkp_o,
    output commit_ctrl_t               commit_ctrl_o,
    output logic                       flush_gl_o,
    output logic [`CU_GL_IDX_W-1:0]    flush_gl_index_o
);

    logic       trap_d;
    logic       trap_q;
    logic       csr_redirect_q;
    logic       mispredict;
    stall_vec_t fe_stall;
    stall_vec_t be_stall;
    flush_vec_t fe_flush;
    flush_vec_t be_flush;

    trap_sequencer u_trap_sequencer (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .commit_i         (commit_i),
        .csr_i            (csr_i),
        .trap_d_o         (trap_d),
        .trap_q_o         (trap_q),
        .csr_redirect_q_o (csr_redirect_q)
    );

    frontend_ctrl u_frontend_ctrl (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .id_i                (id_i),
        .ir_i                (ir_i),
        .commit_i            (commit_i),
        .csr_i               (csr_i),
        .mispredict_i        (mispredict),
        .trap_q_i            (trap_q),
        .csr_redirect_q_i    (csr_redirect_q),
        .miss_icache_i       (miss_icache_i),
        .ready_icache_i      (ready_icache_i),
        .fe_stall_o          (fe_stall),
        .fe_flush_o          (fe_flush),
        .next_pc_o           (next_pc_o),
        .sel_addr_o          (sel_addr_o),
        .invalidate_icache_o (invalidate_icache_o),
        .invalidate_buffer_o (invalidate_buffer_o)
    );

    backend_ctrl u_backend_ctrl (
        .ir_i             (ir_i),
        .rr_i             (rr_i),
        .exe_i            (exe_i),
        .wb_i             (wb_i),
        .commit_i         (commit_i),
        .csr_i            (csr_i),
        .trap_d_i         (trap_d),
        .trap_q_i         (trap_q),
        .mispredict_o     (mispredict),
        .be_stall_o       (be_stall),
        .be_flush_o       (be_flush),
        .chkp_o           (chkp_o),
        .commit_ctrl_o    (commit_ctrl_o),
        .flush_gl_o       (flush_gl_o),
        .flush_gl_index_o (flush_gl_index_o)
    );

    // fetch side from the front end
    assign stall_o.stall_if_1 = fe_stall.stall_if_1;
    assign stall_o.stall_if_2 = fe_stall.stall_if_2;
    assign stall_o.stall_id   = fe_stall.stall_id;

    // rename onwards from the back end
    assign stall_o.stall_iq     = be_stall.stall_iq;
    assign stall_o.stall_ir     = be_stall.stall_ir;
    assign stall_o.stall_rr     = be_stall.stall_rr;
    assign stall_o.stall_exe    = be_stall.stall_exe;
    assign stall_o.stall_commit = be_stall.stall_commit;

    assign flush_o.flush_if  = fe_flush.flush_if;
    assign flush_o.flush_id  = fe_flush.flush_id;
    assign flush_o.flush_ir  = be_flush.flush_ir;
    assign flush_o.flush_rr  = be_flush.flush_rr;
    assign flush_o.flush_exe = be_flush.flush_exe;
    assign flush_o.kill_exe  = be_flush.kill_exe;

endmodule

`default_nettype wire

// ==== rtl/backend_ctrl.sv ====
/*
 * Back-end control
 * Mispredict handling, back-end stalls and flushes, checkpoints and commit
 */
`timescale 1ns/10ps
`default_nettype none

`include "cu_cfg.svh"

module backend_ctrl
    import cu_pkg::*;
(
    input  wire ir_rpt_t               ir_i,
    input  wire rr_rpt_t               rr_i,
    input  wire exe_rpt_t              exe_i,
    input  wire wb_rpt_t               wb_i,
    input  wire commit_rpt_t           commit_i,
    input  wire csr_rpt_t              csr_i,
    input  wire logic                  trap_d_i,
    input  wire logic                  trap_q_i,
    output logic                       mispredict_o,
    output stall_vec_t                 be_stall_o,
    output flush_vec_t                 be_flush_o,
    output chkp_ctrl_t                 chkp_o,
    output commit_ctrl_t               commit_ctrl_o,
    output logic                       flush_gl_o,
    output logic [`CU_GL_IDX_W-1:0]    flush_gl_index_o
);

    logic chkp_resolved;

    // branch resolved wrong at writeback
    assign mispredict_o = wb_i.valid & ~wb_i.correct_pred;

    always_comb begin
        be_flush_o = '0;
        if (trap_q_i) begin
            be_flush_o.flush_ir  = 1'b1;
            be_flush_o.flush_rr  = 1'b1;
            be_flush_o.flush_exe = 1'b1;
        end else if (mispredict_o) begin
            // the resolving branch itself stays in execute
            be_flush_o.flush_ir = 1'b1;
            be_flush_o.flush_rr = 1'b1;
            be_flush_o.kill_exe = 1'b1;
        end else if (rr_i.gl_full & ~exe_i.stall) begin
            be_flush_o.flush_rr = 1'b1;
        end
    end

    always_comb begin
        be_stall_o = '0;
        if (csr_i.csr_stall) begin
            be_stall_o.stall_iq  = 1'b1;
            be_stall_o.stall_ir  = 1'b1;
            be_stall_o.stall_rr  = 1'b1;
            be_stall_o.stall_exe = 1'b1;
        end else if (exe_i.stall | rr_i.gl_full) begin
            be_stall_o.stall_iq = 1'b1;
            be_stall_o.stall_ir = 1'b1;
            be_stall_o.stall_rr = 1'b1;
        end else if (ir_i.empty_free_list | ir_i.out_of_checkpoints) begin
            be_stall_o.stall_iq = 1'b1;
        end
        be_stall_o.stall_commit = commit_i.stall_commit;
    end

    assign chkp_resolved = wb_i.valid & wb_i.checkpoint_done;

    // new checkpoint only when the branch actually advances past rename
    assign chkp_o.do_checkpoint = ir_i.valid & ir_i.is_branch & ~ir_i.out_of_checkpoints &
                                  ~be_flush_o.flush_ir & ~be_stall_o.stall_ir;
    assign chkp_o.do_recover         = chkp_resolved & ~wb_i.correct_pred;
    assign chkp_o.delete_checkpoint  = chkp_resolved & wb_i.correct_pred;
    assign chkp_o.recover_checkpoint = wb_i.chkp;
    assign chkp_o.recover_commit     = trap_q_i;

    // drop younger entries from the graduation list
    assign flush_gl_o       = mispredict_o;
    assign flush_gl_index_o = mispredict_o ? wb_i.gl_index : '0;

    assign commit_ctrl_o.enable_commit   = ~commit_i.stall_commit & ~trap_d_i;
    assign commit_ctrl_o.flush_gl_commit = trap_q_i;

    // a trapping instruction must not update the committed rename state
    assign commit_ctrl_o.enable_commit_update = commit_i.retire & commit_i.regfile_we &
                                                {`CU_RETIRE_W{~trap_d_i}};

endmodule

`default_nettype wire

// ==== rtl/frontend_ctrl.sv ====
/*
 * Front-end control
 * Fetch redirect, fetch stalls and flushes, fence tracking, invalidation
 */
`timescale 1ns/10ps
`default_nettype none

module frontend_ctrl
    import cu_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire id_rpt_t     id_i,
    input  wire ir_rpt_t     ir_i,
    input  wire commit_rpt_t commit_i,
    input  wire csr_rpt_t    csr_i,
    input  wire logic        mispredict_i,
    input  wire logic        trap_q_i,
    input  wire logic        csr_redirect_q_i,
    input  wire logic        miss_icache_i,
    input  wire logic        ready_icache_i,
    output stall_vec_t       fe_stall_o,
    output flush_vec_t       fe_flush_o,
    output next_pc_sel_e     next_pc_o,
    output sel_addr_e        sel_addr_o,
    output logic             invalidate_icache_o,
    output logic             invalidate_buffer_o
);

    logic fence_in_flight_q;
    logic id_fence;
    logic commit_csr_fence;
    logic commit_fence;
    logic false_pred;
    logic jump;
    logic fence_clear;

    assign id_fence         = id_i.valid & id_i.stall_csr_fence;
    assign commit_csr_fence = commit_i.valid & commit_i.stall_csr_fence;
    assign commit_fence     = commit_i.valid & commit_i.fence;

    // decode saw a branch prediction on something that is not a branch
    assign false_pred = id_i.valid & ~id_i.is_branch & id_i.predicted_as_branch;

    assign jump = mispredict_i | false_pred | id_i.valid_jal |
                  trap_q_i | csr_redirect_q_i;

    // fence leaves the pipeline at commit, on a trap or behind a mispredict
    assign fence_clear = commit_csr_fence | trap_q_i | mispredict_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fence_in_flight_q <= 1'b0;
        end else if (fence_clear) begin
            fence_in_flight_q <= 1'b0;
        end else if (id_fence) begin
            fence_in_flight_q <= 1'b1;
        end
    end

    // fetch stalls
    always_comb begin
        fe_stall_o = '0;
        if (csr_i.csr_stall | ir_i.full_iq) begin
            fe_stall_o.stall_if_1 = 1'b1;
            fe_stall_o.stall_if_2 = 1'b1;
            fe_stall_o.stall_id   = 1'b1;
        end else if (miss_icache_i) begin
            fe_stall_o.stall_if_1 = 1'b1;
            fe_stall_o.stall_if_2 = 1'b1;
        end else if (commit_csr_fence | ~ready_icache_i) begin
            fe_stall_o.stall_if_1 = 1'b1;
        end
    end

    always_comb begin
        if (jump) begin
            next_pc_o = NEXT_PC_SEL_JUMP;
        end else if (fe_stall_o.stall_if_1 | id_fence | fence_in_flight_q | commit_fence) begin
            next_pc_o = NEXT_PC_SEL_KEEP_PC;
        end else begin
            next_pc_o = NEXT_PC_SEL_BP_OR_PC_4;
        end
    end

    // target source, trap vector first
    always_comb begin
        if (trap_q_i) begin
            sel_addr_o = SEL_JUMP_CSR;
        end else if (csr_redirect_q_i) begin
            sel_addr_o = SEL_JUMP_CSR_RW;
        end else if (mispredict_i) begin
            sel_addr_o = SEL_JUMP_EXECUTION;
        end else begin
            sel_addr_o = SEL_JUMP_DECODE;
        end
    end

    always_comb begin
        fe_flush_o = '0;
        if (trap_q_i | csr_redirect_q_i | mispredict_i) begin
            fe_flush_o.flush_if = 1'b1;
            fe_flush_o.flush_id = 1'b1;
        end else if ((id_fence | fence_in_flight_q | commit_csr_fence |
                      id_i.valid_jal | commit_fence | false_pred) & ~csr_i.csr_stall) begin
            // only the fetch stage holds wrong-path work here
            fe_flush_o.flush_if = 1'b1;
        end
    end

    // fence.i may follow self-modifying code
    assign invalidate_icache_o = commit_i.valid & commit_i.fence_i;

    assign invalidate_buffer_o = commit_i.valid &
                                 (commit_i.fence_i | trap_q_i |
                                  (commit_i.stall_csr_fence & ~commit_i.fence));

endmodule

`default_nettype wire

// ==== rtl/trap_sequencer.sv ====
/*
 * Trap sequencer
 * One-cycle trap and CSR redirect pulses, delayed so the CSR file settles
 */
`timescale 1ns/10ps
`default_nettype none

module trap_sequencer
    import cu_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rstn_i,
    input  wire commit_rpt_t commit_i,
    input  wire csr_rpt_t    csr_i,
    output logic             trap_d_o,
    output logic             trap_q_o,
    output logic             csr_redirect_q_o
);

    logic trap_cond;
    logic csr_redirect_d;

    // exception, ecall, eret or CSR exception
    assign trap_cond = (commit_i.valid & commit_i.xcpt) |
                       (commit_i.valid & commit_i.ecall_taken) |
                       csr_i.csr_eret |
                       csr_i.csr_exception;

    // blanked while the pulse is out so it lasts a single cycle
    assign trap_d_o = trap_cond & ~trap_q_o;

    // CSR fence redirect loses to any trap in the same cycle
    assign csr_redirect_d = commit_i.valid & commit_i.stall_csr_fence &
                            ~trap_cond & ~csr_redirect_q_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            trap_q_o         <= 1'b0;
            csr_redirect_q_o <= 1'b0;
        end else begin
            trap_q_o         <= trap_d_o;
            csr_redirect_q_o <= csr_redirect_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cu_pkg.sv ====
/*
 * Control unit types
 * Fetch selects, stage reports and pipeline command vectors
 */
`default_nettype none

`include "cu_cfg.svh"

package cu_pkg;

    // next fetch address choice
    typedef enum logic [1:0] {
        NEXT_PC_SEL_JUMP      = 2'b00,
        NEXT_PC_SEL_KEEP_PC   = 2'b01,
        NEXT_PC_SEL_BP_OR_PC_4 = 2'b10
    } next_pc_sel_e;

    // source of the jump target
    typedef enum logic [1:0] {
        SEL_JUMP_CSR       = 2'b00,
        SEL_JUMP_CSR_RW    = 2'b01,
        SEL_JUMP_EXECUTION = 2'b10,
        SEL_JUMP_DECODE    = 2'b11
    } sel_addr_e;

    typedef struct packed {
        logic valid;
        logic valid_jal;
        logic is_branch;
        logic predicted_as_branch;
        logic stall_csr_fence;
    } id_rpt_t;

    typedef struct packed {
        logic valid;
        logic is_branch;
        logic out_of_checkpoints;
        logic empty_free_list;
        logic full_iq;
    } ir_rpt_t;

    typedef struct packed {
        logic gl_full;
    } rr_rpt_t;

    typedef struct packed {
        logic stall;
    } exe_rpt_t;

    // resolved branch at writeback
    typedef struct packed {
        logic                      valid;
        logic                      correct_pred;
        logic                      checkpoint_done;
        logic [`CU_CHKP_W-1:0]     chkp;
        logic [`CU_GL_IDX_W-1:0]   gl_index;
    } wb_rpt_t;

    typedef struct packed {
        logic                      valid;
        logic                      xcpt;
        logic                      ecall_taken;
        logic                      stall_csr_fence;
        logic                      fence;
        logic                      fence_i;
        logic                      stall_commit;
        logic [`CU_RETIRE_W-1:0]   retire;
        logic [`CU_RETIRE_W-1:0]   regfile_we;
    } commit_rpt_t;

    typedef struct packed {
        logic csr_eret;
        logic csr_exception;
        logic csr_stall;
    } csr_rpt_t;

    typedef struct packed {
        logic stall_if_1;
        logic stall_if_2;
        logic stall_id;
        logic stall_iq;
        logic stall_ir;
        logic stall_rr;
        logic stall_exe;
        logic stall_commit;
    } stall_vec_t;

    typedef struct packed {
        logic flush_if;
        logic flush_id;
        logic flush_ir;
        logic flush_rr;
        logic flush_exe;
        logic kill_exe;
    } flush_vec_t;

    // rename and free list checkpoint commands
    typedef struct packed {
        logic                      do_checkpoint;
        logic                      do_recover;
        logic                      delete_checkpoint;
        logic [`CU_CHKP_W-1:0]     recover_checkpoint;
        logic                      recover_commit;
    } chkp_ctrl_t;

    typedef struct packed {
        logic                      enable_commit;
        logic                      flush_gl_commit;
        logic [`CU_RETIRE_W-1:0]   enable_commit_update;
    } commit_ctrl_t;

endpackage

`default_nettype wire

// ==== include/cu_cfg.svh ====
/*
 * Control unit configuration
 * Widths shared by the report and command types
 */
`ifndef CU_CFG_SVH
`define CU_CFG_SVH

// graduation list holds 64 entries
`define CU_GL_IDX_W 6

// four rename checkpoints
`define CU_CHKP_W 2

// instructions retired per cycle
`define CU_RETIRE_W 2

`endif
